//--- source/displayPkg.sv
package displayPkg;

	// screen coordinates, 160x120 fits in 8 by 7 bits
	typedef logic [7:0] xCoordT; // pixel column
	typedef logic [6:0] yCoordT; // pixel row

	// 3-bit rgb colour
	typedef logic [2:0] colourT;

	localparam colourT colourBlack = 3'b000; // background and clear
	localparam colourT colourOn = 3'b110; // yellow, item switched on
	localparam colourT colourOff = 3'b111; // white, item switched off

	// one pixel as it leaves on the stream
	typedef struct packed {
		xCoordT x; // column
		yCoordT y; // row
		colourT colour; // rgb
	} pixelT;

	// edge of a status tile in pixels
	localparam int tileSize = 4;

endpackage

//--- source/homePkg.sv
package homePkg;

	localparam int roomCount = 5; // rooms shown on the panel

	typedef logic [2:0] roomIdT; // room number, 0 to roomCount-1

	typedef enum logic {
		itemDoor = 1'b0,
		itemLight = 1'b1
	} itemT;

	// stored state of one room, bit 0 light and bit 1 door
	typedef struct packed {
		logic door;
		logic light;
	} roomStatusT;

	// one tile to draw
	typedef struct packed {
		roomIdT room;
		itemT item;
		logic on;
	} tileRequestT;

	// apb register map
	localparam logic [7:0] commandAddr = 8'h00; // write, room/item/on
	localparam logic [7:0] clearAddr = 8'h04; // write, blank the screen
	localparam logic [7:0] statusBaseAddr = 8'h08; // read, one word per room
	localparam int itemBit = 4; // command data bit, 1 is light
	localparam int onBit = 8; // command data bit, 1 is on

	// tile placement
	localparam int roomPitchX = 32;
	localparam int roomOriginX = 16;
	localparam int roomOriginY = 48;
	localparam int doorOffsetX = 8;

	// left column of a tile; door sits to the right of the light
	function automatic logic [7:0] tileBaseX(roomIdT room, itemT item);
		logic [7:0] base;
		base = 8'(roomPitchX * int'(room) + roomOriginX);
		return (item == itemDoor) ? 8'(base + doorOffsetX) : base;
	endfunction

endpackage

//--- source/apbCommandPort.sv
module apbCommandPort (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output homePkg::tileRequestT startTile,
	output logic tileGo,
	output logic startClear,
	input logic jobDone
);
	import homePkg::*;

	typedef enum logic [1:0] {
		portIdle, // waiting for an access phase
		portBusy, // job running, pready held low
		portDone // job finished, complete the transfer
	} portStateT;

	portStateT portState;
	roomStatusT roomStatus [roomCount]; // status table, one entry per room

	logic accessStart; // first access cycle of a transfer
	logic isCommand;
	logic isClear;
	logic isStatus;
	logic [7:0] statusOffset; // address relative to the status block
	roomIdT statusRoom; // room addressed by a status read
	roomIdT commandRoom; // room carried in the command data
	logic roomOk;
	logic jobWrite; // write that starts a draw or clear
	logic badAccess; // unmapped address or room out of range

	assign accessStart = psel & penable & (portState == portIdle);

	// address decode
	assign isCommand = (paddr == commandAddr);
	assign isClear = (paddr == clearAddr);
	assign statusOffset = paddr - statusBaseAddr;
	assign isStatus = (paddr >= statusBaseAddr) && (paddr[1:0] == 2'b00)
		&& (statusOffset < 8'(4 * roomCount));
	assign statusRoom = roomIdT'(statusOffset >> 2);

	// command fields
	assign commandRoom = roomIdT'(pwdata[2:0]);
	assign roomOk = (commandRoom < roomCount);
	assign startTile = '{room: commandRoom, item: itemT'(pwdata[itemBit]), on: pwdata[onBit]};

	assign jobWrite = pwrite & ((isCommand & roomOk) | isClear);
	assign badAccess = pwrite ? ~jobWrite : ~isStatus; // status block is read only

	// job start pulses, only from the first access cycle
	assign tileGo = accessStart & pwrite & isCommand & roomOk;
	assign startClear = accessStart & pwrite & isClear;

	// reads and rejected writes finish at once, jobs wait for the sequencer
	assign pready = (portState == portDone) | (accessStart & ~jobWrite);
	assign pslverr = accessStart & badAccess;
	assign prdata = (accessStart & ~pwrite & isStatus)
		? {30'b0, roomStatus[statusRoom]} : 32'b0;

	always_ff @(posedge clock) begin
		if (reset) begin
			portState <= portIdle;
		end else begin
			case (portState)
				portIdle: if (accessStart & jobWrite) portState <= portBusy;
				portBusy: if (jobDone) portState <= portDone; // pready next cycle
				default: portState <= portIdle; // transfer ends here
			endcase
		end
	end

	// status table follows accepted commands
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < roomCount; r++) begin
				roomStatus[r] <= '0; // everything off
			end
		end else if (tileGo) begin
			if (startTile.item == itemLight) begin
				roomStatus[commandRoom].light <= startTile.on;
			end else begin
				roomStatus[commandRoom].door <= startTile.on;
			end
		end
	end

endmodule

//--- source/drawSequencer.sv
module drawSequencer (
	input logic clock,
	input logic reset,
	input logic tileGo,
	input logic startClear,
	output logic jobDone,
	output logic tileStart,
	output logic clearStart,
	input displayPkg::pixelT tilePixel,
	input displayPkg::pixelT clearPixel,
	input logic tileLast,
	input logic clearLast,
	output logic tileAdvance,
	output logic clearAdvance,
	output displayPkg::pixelT pixelOut,
	output logic pixelValid,
	input logic pixelReady
);

	typedef enum logic [1:0] {
		seqIdle,
		seqTile, // placer owns the stream
		seqClear // clearer owns the stream
	} seqStateT;

	seqStateT seqState;
	seqStateT seqNext;

	// launch the worker in the same cycle so its first pixel is ready next cycle
	assign tileStart = (seqState == seqIdle) & tileGo;
	assign clearStart = (seqState == seqIdle) & ~tileGo & startClear;

	// the busy worker's pixel goes out
	assign pixelValid = (seqState != seqIdle);
	assign pixelOut = (seqState == seqClear) ? clearPixel : tilePixel;

	// a worker steps only when its pixel is taken
	assign tileAdvance = (seqState == seqTile) & pixelReady;
	assign clearAdvance = (seqState == seqClear) & pixelReady;

	// last transfer of the job
	assign jobDone = (tileAdvance & tileLast) | (clearAdvance & clearLast);

	always_comb begin
		seqNext = seqState;
		case (seqState)
			seqIdle: begin
				if (tileGo) begin
					seqNext = seqTile;
				end else if (startClear) begin
					seqNext = seqClear;
				end
			end
			seqTile: if (tileAdvance & tileLast) seqNext = seqIdle;
			seqClear: if (clearAdvance & clearLast) seqNext = seqIdle;
			default: seqNext = seqIdle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			seqState <= seqIdle;
		end else begin
			seqState <= seqNext;
		end
	end

endmodule

//--- source/tilePlacer.sv
module tilePlacer (
	input logic clock,
	input logic reset,
	input logic tileStart,
	input homePkg::tileRequestT request,
	input logic advance,
	output displayPkg::pixelT pixel,
	output logic last
);
	import displayPkg::*;
	import homePkg::*;

	localparam int edgeBits = $clog2(tileSize); // bits per tile axis
	localparam int countBits = 2 * edgeBits;
	localparam logic [countBits-1:0] lastCount = countBits'(tileSize * tileSize - 1);
	localparam yCoordT baseY = yCoordT'(roomOriginY); // every tile shares this row

	tileRequestT heldRequest; // request of the tile being drawn
	logic [countBits-1:0] count; // pixel index inside the tile
	xCoordT baseX;

	// payload latch, no reset
	always_ff @(posedge clock) begin
		if (tileStart) begin
			heldRequest <= request;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (tileStart) begin
			count <= '0;
		end else if (advance) begin
			count <= count + 1'b1; // wraps after the last pixel
		end
	end

	assign baseX = tileBaseX(heldRequest.room, heldRequest.item);

	// row-major, low count bits walk the columns
	assign pixel.x = baseX + xCoordT'(count[edgeBits-1:0]);
	assign pixel.y = baseY + yCoordT'(count[countBits-1:edgeBits]);
	assign pixel.colour = heldRequest.on ? colourOn : colourOff;

	assign last = (count == lastCount);

endmodule

//--- source/screenClearer.sv
module screenClearer #(
	parameter int screenWidth = 160,
	parameter int screenHeight = 120
) (
	input logic clock,
	input logic reset,
	input logic clearStart,
	input logic advance,
	output displayPkg::pixelT pixel,
	output logic last
);
	import displayPkg::*;

	localparam xCoordT lastX = xCoordT'(screenWidth - 1);
	localparam yCoordT lastY = yCoordT'(screenHeight - 1);

	xCoordT xCount; // raster column
	yCoordT yCount; // raster row

	always_ff @(posedge clock) begin
		if (reset || clearStart) begin
			xCount <= '0;
			yCount <= '0;
		end else if (advance) begin
			if (xCount == lastX) begin
				xCount <= '0; // next row
				yCount <= (yCount == lastY) ? '0 : yCount + 1'b1;
			end else begin
				xCount <= xCount + 1'b1;
			end
		end
	end

	assign pixel = '{x: xCount, y: yCount, colour: colourBlack};
	assign last = (xCount == lastX) && (yCount == lastY); // bottom-right corner

endmodule

//--- source/roomPanelTop.sv
module roomPanelTop #(
	parameter int screenWidth = 160,
	parameter int screenHeight = 120
) (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output displayPkg::pixelT pixelOut,
	output logic pixelValid,
	input logic pixelReady
);
	import displayPkg::*;
	import homePkg::*;

	tileRequestT tileRequest; // decoded command, valid with tileGo
	logic tileGo; // port wants a tile drawn
	logic startClear; // port wants a clear
	logic jobDone; // last pixel of the job taken

	logic tileStart; // sequencer launching the placer
	logic clearStart; // sequencer launching the clearer
	pixelT tilePixel;
	pixelT clearPixel;
	logic tileLast;
	logic clearLast;
	logic tileAdvance;
	logic clearAdvance;

	apbCommandPort apbCommandPort_i (
		.clock(clock),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.startTile(tileRequest),
		.tileGo(tileGo),
		.startClear(startClear),
		.jobDone(jobDone)
	);

	drawSequencer drawSequencer_i (
		.clock(clock),
		.reset(reset),
		.tileGo(tileGo),
		.startClear(startClear),
		.jobDone(jobDone),
		.tileStart(tileStart),
		.clearStart(clearStart),
		.tilePixel(tilePixel),
		.clearPixel(clearPixel),
		.tileLast(tileLast),
		.clearLast(clearLast),
		.tileAdvance(tileAdvance),
		.clearAdvance(clearAdvance),
		.pixelOut(pixelOut),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady)
	);

	tilePlacer tilePlacer_i (
		.clock(clock),
		.reset(reset),
		.tileStart(tileStart),
		.request(tileRequest),
		.advance(tileAdvance),
		.pixel(tilePixel),
		.last(tileLast)
	);

	screenClearer #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight)
	) screenClearer_i (
		.clock(clock),
		.reset(reset),
		.clearStart(clearStart),
		.advance(clearAdvance),
		.pixel(clearPixel),
		.last(clearLast)
	);

endmodule

//--- verif/roomPanel_checker.sv
module roomPanel_checker #(
	parameter int screenWidth = 160,
	parameter int screenHeight = 120
) (
	input logic clock,
	input logic reset,
	input displayPkg::pixelT pixelOut,
	input logic pixelValid,
	input logic pixelReady,
	input logic jobDone
);

	// a stalled pixel waits unchanged until it is taken
	stallHold: assert property (@(posedge clock) disable iff (reset)
		(pixelValid && !pixelReady) |=> (pixelValid && $stable(pixelOut)))
		else $error("pixel changed or dropped while the stream was stalled");

	// every pixel lands on the visible screen
	onScreen: assert property (@(posedge clock) disable iff (reset)
		pixelValid |-> ((int'(pixelOut.x) < screenWidth) && (int'(pixelOut.y) < screenHeight)))
		else $error("pixel outside the screen at x %0d y %0d", pixelOut.x, pixelOut.y);

	// a job ends on a taken pixel and the stream falls idle right after
	doneBusy: assert property (@(posedge clock) disable iff (reset)
		jobDone |-> (pixelValid && pixelReady) ##1 !pixelValid)
		else $error("job done pulse outside a final transfer, or stream still busy after it");

endmodule

//--- verif/roomPanelTb.sv
module roomPanelTb;
	import displayPkg::*;
	import homePkg::*;

	localparam int screenWidth = 160;
	localparam int screenHeight = 120;
	localparam int transferLimit = 100000; // cycles allowed for one apb transfer

	logic clock = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	pixelT pixelOut;
	logic pixelValid;
	logic pixelReady;

	logic [31:0] rngState = 32'hface; // xorshift state
	int failCount = 0; // tests with at least one error
	int testCount = 0;
	int testErrors; // errors in the running test
	logic timedOut = 1'b0;
	string testName;
	string op; // r or w
	logic [7:0] addr;
	logic [31:0] data;
	logic [31:0] expectValue; // expected prdata of a read
	int expectErr; // expected pslverr
	int stall; // 1 randomises pixelReady
	logic jobClear; // running job is a clear
	int tileX; // left column of the expected tile
	colourT tileColour;
	int expectedCount; // pixels the transfer should produce
	logic [31:0] readData;
	logic readErr;

	roomPanelTop #(
		.screenWidth(screenWidth),
		.screenHeight(screenHeight)
	) roomPanelTop_i (
		.clock(clock),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.pixelOut(pixelOut),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady)
	);

	bind drawSequencer roomPanel_checker roomPanelChecker_i (
		.clock(clock),
		.reset(reset),
		.pixelOut(pixelOut),
		.pixelValid(pixelValid),
		.pixelReady(pixelReady),
		.jobDone(jobDone)
	);

	always #10 clock = ~clock; // 20 unit period

	function automatic logic [31:0] xorshift(logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic compareValue(string what, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	// pixel n of the running job, straight from the placement and raster rules
	function automatic pixelT expectedPixel(int index);
		pixelT p;
		if (jobClear) begin
			p.x = xCoordT'(index % screenWidth);
			p.y = yCoordT'(index / screenWidth);
			p.colour = colourBlack;
		end else begin
			p.x = xCoordT'(tileX + index % tileSize); // row-major inside the tile
			p.y = yCoordT'(roomOriginY + index / tileSize);
			p.colour = tileColour;
		end
		return p;
	endfunction

	// one apb transfer, collecting pixels until pready
	task automatic runTransfer();
		int cycles;
		int pixelCount;
		logic done;
		cycles = 0;
		pixelCount = 0;
		done = 1'b0;
		@(negedge clock);
		psel = 1'b1; // setup phase
		pwrite = (op == "w");
		paddr = addr;
		pwdata = data;
		@(negedge clock);
		penable = 1'b1; // access phase
		while (!done && !timedOut) begin
			if (stall != 0) begin
				rngState = xorshift(rngState);
				pixelReady = rngState[7];
			end else begin
				pixelReady = 1'b1;
			end
			@(posedge clock);
			if (pixelValid && pixelReady) begin
				if (pixelCount < expectedCount) begin
					compareValue("pixel", 32'(expectedPixel(pixelCount)), 32'(pixelOut));
				end
				pixelCount++;
			end
			if (pready) begin
				done = 1'b1;
				readData = prdata;
				readErr = pslverr;
			end
			cycles++;
			if (!done && cycles > transferLimit) begin
				$display("timeout: pready never came in test %s", testName);
				timedOut = 1'b1;
			end
			@(negedge clock);
		end
		psel = 1'b0;
		penable = 1'b0;
		pixelReady = 1'b1;
		compareValue("pixel count", 32'(expectedCount), 32'(pixelCount));
		@(posedge clock);
		compareValue("valid after transfer", 32'(0), 32'(pixelValid)); // stream idle again
	endtask

	initial begin
		int fd;
		int code;
		string line;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		pixelReady = 1'b1;
		repeat (10) @(negedge clock);
		reset = 1'b0;
		testName = "reset";
		testErrors = 0;
		@(posedge clock);
		compareValue("pixelValid", 32'(0), 32'(pixelValid));
		compareValue("pready", 32'(0), 32'(pready));
		compareValue("pslverr", 32'(0), 32'(pslverr));
		$display("test %s: %0d errors", testName, testErrors);
		testCount++;
		failCount += (testErrors != 0);

		fd = $fopen("verif/roomPanel_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verif/roomPanel_stimulus.txt");
			failCount++;
		end else begin
			while (!timedOut && !$feof(fd)) begin
				code = $fscanf(fd, " %s", testName);
				if (code != 1) break;
				if (testName[0] == "#") begin
					code = $fgets(line, fd); // rest of a column note
					continue;
				end
				code = $fscanf(fd, " %s %h %h %h %d %d", op, addr, data, expectValue,
					expectErr, stall);
				if (code != 6) begin
					$display("stimulus line of test %s has missing or bad fields", testName);
					failCount++;
					break;
				end
				testErrors = 0;
				expectedCount = 0;
				jobClear = (addr == clearAddr);
				tileX = roomPitchX * int'(data[2:0]) + roomOriginX
					+ (data[itemBit] ? 0 : doorOffsetX); // door right of the light
				tileColour = data[onBit] ? colourOn : colourOff;
				if (op == "w" && expectErr == 0) begin
					expectedCount = jobClear ? screenWidth * screenHeight : tileSize * tileSize;
				end
				runTransfer();
				if (op == "r") begin
					compareValue("prdata", expectValue, readData);
				end
				compareValue("pslverr", 32'(expectErr), 32'(readErr));
				$display("test %s: %0d errors", testName, testErrors);
				testCount++;
				failCount += (testErrors != 0);
			end
			$fclose(fd);
		end

		$display("tests run %0d, failed %0d", testCount, failCount);
		if (failCount == 0 && !timedOut) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- verif/roomPanel_stimulus.txt
# columns: name op(r/w) addr(hex) data(hex) expected_read(hex) pslverr stall
# command data: bits 2..0 room, bit 4 light (else door), bit 8 on; stall 1 randomises pixelReady
idle_room0 r 08 00000000 00000000 0 0
idle_room1 r 0c 00000000 00000000 0 0
idle_room2 r 10 00000000 00000000 0 0
idle_room3 r 14 00000000 00000000 0 0
idle_room4 r 18 00000000 00000000 0 0
light_on_r0 w 00 00000110 00000000 0 0
door_on_r0 w 00 00000100 00000000 0 0
status_r0 r 08 00000000 00000003 0 0
door_off_r2 w 00 00000002 00000000 0 0
light_on_r2 w 00 00000112 00000000 0 0
status_r2 r 10 00000000 00000001 0 0
light_on_r4 w 00 00000114 00000000 0 0
door_on_r3 w 00 00000103 00000000 0 0
light_off_r0 w 00 00000010 00000000 0 0
status_r0_door_kept r 08 00000000 00000002 0 0
status_r3 r 14 00000000 00000002 0 0
bad_room5 w 00 00000115 00000000 1 0
bad_room7 w 00 00000107 00000000 1 0
bad_addr w 20 00000000 00000000 1 0
bad_status_write w 0c 00000003 00000000 1 0
bad_read r 40 00000000 00000000 1 0
status_r1_untouched r 0c 00000000 00000000 0 0
clear w 04 00000000 00000000 0 0
status_r2_after_clear r 10 00000000 00000001 0 0
rand_light_r1 w 00 00000111 00000000 0 1
rand_door_r4 w 00 00000104 00000000 0 1
rand_clear w 04 00000000 00000000 0 1
rand_status_r1 r 0c 00000000 00000001 0 1
rand_status_r4 r 18 00000000 00000003 0 1

//--- build.f
source/displayPkg.sv
source/homePkg.sv
source/apbCommandPort.sv
source/drawSequencer.sv
source/tilePlacer.sv
source/screenClearer.sv
source/roomPanelTop.sv
verif/roomPanel_checker.sv
verif/roomPanelTb.sv

//--- Makefile
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = roomPanelTb
FILELIST = build.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
